// ==== cpuCore.f ====
+incdir+common
+incdir+tb
common/cpuPkg.sv
alu/lacTree.sv
alu/alu64.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/executeStage.sv
hdl/cpuCore.sv
tb/cpuCoreTb.sv

// ==== tb/tbProgram.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// R and D formats use 11-bit opcodes and the I format 10-bit ones
localparam logic [10:0] OpAdd   = 11'b001010_00000;
localparam logic [10:0] OpAnd   = 11'b001010_00010;
localparam logic [10:0] OpEor   = 11'b001010_00100;
localparam logic [10:0] OpEnor  = 11'b001010_00101;
localparam logic [10:0] OpLsl   = 11'b001010_00110;
localparam logic [10:0] OpLsr   = 11'b001010_00111;
localparam logic [10:0] OpOrr   = 11'b001010_01000;
localparam logic [10:0] OpSub   = 11'b001010_01001;
localparam logic [10:0] OpLdur  = 11'b110100_00000;
localparam logic [10:0] OpStur  = 11'b110100_00001;
localparam logic [9:0]  OpAddi  = 10'b100010_0000;
localparam logic [9:0]  OpAndi  = 10'b100010_0010;
localparam logic [9:0]  OpEori  = 10'b100010_0100;
localparam logic [9:0]  OpEnori = 10'b100010_0101;
localparam logic [9:0]  OpOrri  = 10'b100010_0110;
localparam logic [9:0]  OpSubi  = 10'b100010_0111;

// Stores go to BaseReg plus eight times the slot number
localparam int BaseReg = 10;
int storeSlot;

function automatic instr_t rFmt(logic [10:0] op, int rd, int rn, int rm, int shamt);
    return {op, 5'(rm), 6'(shamt), 5'(rn), 5'(rd)};
endfunction

function automatic instr_t iFmt(logic [9:0] op, int rd, int rn, int imm);
    return {op, 12'(imm), 5'(rn), 5'(rd)};
endfunction

function automatic instr_t dFmt(logic [10:0] op, int rt, int rn, int offset);
    return {op, 9'(offset), 2'b00, 5'(rn), 5'(rt)};
endfunction

// Three NOPs after every instruction since the core has no forwarding
task automatic emit(instr_t word);
    prog.push_back(word);
    repeat (3) prog.push_back('0);
endtask

task automatic storeReg(int rt);
    emit(dFmt(OpStur, rt, BaseReg, 8 * storeSlot));
    storeSlot++;
endtask

task automatic buildProgram();
    logic [10:0] rOps [6];
    logic [9:0]  iOps [6];
    int          shifts [4];
    int          k;
    rOps      = '{OpAdd, OpSub, OpAnd, OpOrr, OpEor, OpEnor};
    iOps      = '{OpAddi, OpSubi, OpAndi, OpOrri, OpEori, OpEnori};
    shifts    = '{1, 13, 40, 63};
    storeSlot = 0;
    // First access reaches the memory stage three cycles after reset
    emit(dFmt(OpStur, 31, 31, 16));
    for (k = 1; k <= 6; k++)
        emit(iFmt(OpAddi, k, 31, $random(seed) & 'hFFF));
    emit(iFmt(OpAddi, BaseReg, 31, 'h200));
    for (k = 0; k < 6; k++)
    begin
        emit(rFmt(rOps[k], 20, k + 1, 6 - k, 0));
        storeReg(20);
    end
    for (k = 0; k < 6; k++)
    begin
        emit(iFmt(iOps[k], 21, k + 1, $random(seed) & 'hFFF));
        storeReg(21);
    end
    // All-ones imm12 leaves the upper bits of X1 clear only when zero-extended
    emit(iFmt(OpEori, 21, 1, 'hFFF));
    storeReg(21);
    for (k = 0; k < 4; k++)
    begin
        emit(rFmt(OpLsl, 22, 1, 0, shifts[k]));
        storeReg(22);
        emit(rFmt(OpLsr, 23, 22, 0, shifts[k] / 2));
        storeReg(23);
    end
    // Negative offsets address below the base
    emit(dFmt(OpStur, 4, BaseReg, -8));
    emit(dFmt(OpLdur, 24, BaseReg, -8));
    storeReg(24);
    emit(dFmt(OpLdur, 25, BaseReg, -16));
    storeReg(25);
    // Zero register
    emit(iFmt(OpAddi, 31, 1, 5));
    emit(rFmt(OpAdd, 26, 31, 2, 0));
    storeReg(26);
    storeReg(31);
    // Unknown opcodes in no group, the R group and the D group
    emit({11'h7FF, 16'h0000, 5'd5});
    emit(rFmt(11'b001010_11111, 6, 1, 2, 0));
    emit(dFmt(11'b110100_00010, 7, BaseReg, 0));
    storeReg(5);
    storeReg(6);
    storeReg(7);
endtask

// Runs the program one instruction at a time on a model register file
function automatic void refRun();
    word_t       r [32];
    word_t       a;
    word_t       b;
    word_t       res;
    word_t       addr;
    logic [10:0] op;
    logic        wr;
    foreach (r[i])
        r[i] = '0;
    expLoads = 0;
    foreach (prog[k])
    begin
        op   = prog[k][31:21];
        a    = r[prog[k][9:5]];
        b    = r[prog[k][20:16]];
        addr = a + {{55{prog[k][20]}}, prog[k][20:12]};
        res  = '0;
        wr   = 1'b1;
        case (op)
            OpAdd:  res = a + b;
            OpSub:  res = a - b;
            OpAnd:  res = a & b;
            OpOrr:  res = a | b;
            OpEor:  res = a ^ b;
            OpEnor: res = ~(a ^ b);
            OpLsl:  res = a << prog[k][15:10];
            OpLsr:  res = a >> prog[k][15:10];
            OpLdur:
            begin
                res = expMem[addr[10:3]];
                expLoads++;
            end
            OpStur:
            begin
                wr = 1'b0;
                expAddr.push_back(addr);
                expData.push_back(r[prog[k][4:0]]);
                expMem[addr[10:3]] = r[prog[k][4:0]];
            end
            default:
            begin
                b = word_t'(prog[k][21:10]);
                case (op[10:1])
                    OpAddi:  res = a + b;
                    OpSubi:  res = a - b;
                    OpAndi:  res = a & b;
                    OpOrri:  res = a | b;
                    OpEori:  res = a ^ b;
                    OpEnori: res = ~(a ^ b);
                    default: wr = 1'b0;
                endcase
            end
        endcase
        if (wr && (prog[k][4:0] != 5'd31))
            r[prog[k][4:0]] = res;
    end
endfunction

`endif

// ==== tb/cpuCoreTb.sv ====
`timescale 1ns/10ps

module cpuCoreTb;
    import cpuPkg::*;

    logic    clk = 1'b0;
    logic    reset;
    instr_t  instr;
    word_t   iaddr;
    memReq_t memReq;
    word_t   memRdata;

    integer seed = 45;
    instr_t prog [$];
    word_t  expAddr [$];
    word_t  expData [$];
    word_t  dmem [0:255];
    word_t  expMem [0:255];
    int     expLoads;
    int     loadCount = 0;
    int     errors = 0;
    int     checks = 0;
    int     postCyc = 0;
    int     totalCyc = 0;

    `include "tbProgram.svh"

    cpuCore i_cpuCore (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .iaddr    (iaddr),
        .memReq   (memReq),
        .memRdata (memRdata)
    );

    always #2 clk = ~clk;

    // Fill value differs for every word index
    function automatic word_t fillWord(int idx);
        return {8'hA5, 24'(idx * 7), 8'h5A, 24'(idx)};
    endfunction

    task automatic checkValue(string what, word_t got, word_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Cycle counters and the run limit
    always @(posedge clk)
    begin
        totalCyc <= totalCyc + 1;
        if (reset)
            postCyc <= 0;
        else
            postCyc <= postCyc + 1;
        if (totalCyc >= 8 + prog.size() + 20)
        begin
            $display("Timeout after %0d cycles, the program never drained", totalCyc);
            $display("Something failed");
            $finish;
        end
    end

    // Memories answer on the falling edge while the DUT samples on the rising one
    always @(negedge clk)
    begin
        instr = (iaddr < 4 * prog.size()) ? prog[iaddr >> 2] : '0;
        if (postCyc < 3)
            checkValue("request before first access", word_t'({memReq.read, memReq.write}), '0);
        if (postCyc == 3)
            checkValue("write flag of first store", word_t'(memReq.write), 1);
        if (memReq.read)
            loadCount++;
        if (memReq.write)
        begin
            if (expAddr.size() == 0)
            begin
                errors++;
                $display("Store to address %h at time %0t was not expected", memReq.addr, $time);
            end
            else
            begin
                checkValue("store address", memReq.addr, expAddr.pop_front());
                checkValue("store data", memReq.wdata, expData.pop_front());
            end
            dmem[memReq.addr[10:3]] = memReq.wdata;
        end
        memRdata = dmem[memReq.addr[10:3]];
    end

    initial
    begin
        int idx;
        reset    = 1'b1;
        instr    = '0;
        memRdata = '0;
        for (idx = 0; idx < 256; idx++)
        begin
            dmem[idx]   = fillWord(idx);
            expMem[idx] = fillWord(idx);
        end
        buildProgram();
        refRun();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Last instruction retires four cycles after its fetch
        wait (postCyc >= prog.size() + 4);
        @(negedge clk);
        if (expAddr.size() != 0)
        begin
            errors++;
            $display("%0d expected stores never reached the data memory", expAddr.size());
        end
        checkValue("load request count", loadCount, expLoads);
        for (idx = 0; idx < 256; idx++)
            checkValue($sformatf("memory word %0d", idx), dmem[idx], expMem[idx]);

        $display("Run finished with %0d checks and %0d errors", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== hdl/cpuCore.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpuCore (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::instr_t  instr,
    output cpuPkg::word_t   iaddr,
    output cpuPkg::memReq_t memReq,
    input  cpuPkg::word_t   memRdata
);
    import cpuPkg::*;

    word_t   pc;
    instr_t  idInstr;
    ctrl_t   idCtrl;
    regIdx_t rnIdx;
    regIdx_t rmIdx;
    regIdx_t wrIdx;
    word_t   immValue;
    word_t   rnData;
    word_t   rmData;
    word_t   wrData;
    logic    wrEn;

    // Fetch, no branches so the PC only steps forward
    // An all-zero IF/ID word decodes as a NOP
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc      <= '0;
            idInstr <= '0;
        end
        else
        begin
            pc      <= pc + `PC_STEP;
            idInstr <= instr;
        end
    end

    assign iaddr = pc;

    instrDecoder i_instrDecoder (
        .instrWord (idInstr),
        .ctrl      (idCtrl),
        .rnIdx     (rnIdx),
        .rmIdx     (rmIdx),
        .immValue  (immValue)
    );

    regFile i_regFile (
        .clk    (clk),
        .reset  (reset),
        .rnIdx  (rnIdx),
        .rmIdx  (rmIdx),
        .rnData (rnData),
        .rmData (rmData),
        .wrEn   (wrEn),
        .wrIdx  (wrIdx),
        .wrData (wrData)
    );

    executeStage i_executeStage (
        .clk      (clk),
        .reset    (reset),
        .ctrlIn   (idCtrl),
        .rnData   (rnData),
        .rmData   (rmData),
        .immValue (immValue),
        .memReq   (memReq),
        .memRdata (memRdata),
        .wrEn     (wrEn),
        .wrIdx    (wrIdx),
        .wrData   (wrData)
    );

endmodule

// ==== hdl/executeStage.sv ====
`timescale 1ns/10ps

module executeStage (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::ctrl_t   ctrlIn,
    input  cpuPkg::word_t   rnData,
    input  cpuPkg::word_t   rmData,
    input  cpuPkg::word_t   immValue,
    output cpuPkg::memReq_t memReq,
    input  cpuPkg::word_t   memRdata,
    output logic            wrEn,
    output cpuPkg::regIdx_t wrIdx,
    output cpuPkg::word_t   wrData
);
    import cpuPkg::*;

    ctrl_t exCtrl;
    ctrl_t memCtrl;
    ctrl_t wbCtrl;
    word_t exA;
    word_t exRm;
    word_t exImm;
    word_t aluB;
    word_t aluResult;
    word_t memAddr;
    word_t memWdata;
    word_t wbData;

    // Control chain ID/EX -> EX/MEM -> MEM/WB, bubbles out of reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            exCtrl  <= CtrlNop;
            memCtrl <= CtrlNop;
            wbCtrl  <= CtrlNop;
        end
        else
        begin
            exCtrl  <= ctrlIn;
            memCtrl <= exCtrl;
            wbCtrl  <= memCtrl;
        end
    end

    always_ff @(posedge clk)
    begin
        exA      <= rnData;
        exRm     <= rmData;
        exImm    <= immValue;
        memAddr  <= aluResult;
        memWdata <= exRm;
        // Load data or ALU result, picked on the way into MEM/WB
        wbData   <= memCtrl.memRead ? memRdata : memAddr;
    end

    assign aluB = exCtrl.useImm ? exImm : exRm;

    alu64 i_alu64 (
        .aluOp  (exCtrl.aluOp),
        .a      (exA),
        .b      (aluB),
        .result (aluResult)
    );

    assign memReq = '{
        addr:  memAddr,
        wdata: memWdata,
        read:  memCtrl.memRead,
        write: memCtrl.memWrite
    };

    assign wrEn   = wbCtrl.regWrite;
    assign wrIdx  = wbCtrl.dest;
    assign wrData = wbData;

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module regFile (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::regIdx_t rnIdx,
    input  cpuPkg::regIdx_t rmIdx,
    output cpuPkg::word_t   rnData,
    output cpuPkg::word_t   rmData,
    input  logic            wrEn,
    input  cpuPkg::regIdx_t wrIdx,
    input  cpuPkg::word_t   wrData
);
    import cpuPkg::*;

    // No storage behind the zero register
    word_t regs [0:`ZERO_REG-1];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `ZERO_REG; i++)
                regs[i] <= '0;
        end
        else if (wrEn && (wrIdx != regIdx_t'(`ZERO_REG)))
            regs[wrIdx] <= wrData;
    end

    // Same-cycle write shows up on the read port
    function automatic word_t readPort(regIdx_t idx);
        if (idx == regIdx_t'(`ZERO_REG))
            return '0;
        else if (wrEn && (wrIdx == idx))
            return wrData;
        else
            return regs[idx];
    endfunction

    always_comb
    begin
        rnData = readPort(rnIdx);
        rmData = readPort(rmIdx);
    end

endmodule

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module instrDecoder (
    input  cpuPkg::instr_t  instrWord,
    output cpuPkg::ctrl_t   ctrl,
    output cpuPkg::regIdx_t rnIdx,
    output cpuPkg::regIdx_t rmIdx,
    output cpuPkg::word_t   immValue
);
    import cpuPkg::*;

    // Upper six opcode bits pick the format
    localparam logic [5:0] GroupR = 6'b001010;
    localparam logic [5:0] GroupI = 6'b100010;
    localparam logic [5:0] GroupD = 6'b110100;

    logic [`OPCODE_MSB-`OPCODE_LSB:0] opcode;
    regIdx_t     rdIdx;
    instrClass_t iClass;

    assign opcode = instrWord[`OPCODE_MSB:`OPCODE_LSB];
    assign rdIdx  = instrWord[`RD_MSB:`RD_LSB];
    assign rnIdx  = instrWord[`RN_MSB:`RN_LSB];

    always_comb
    begin
        ctrl      = CtrlNop;
        ctrl.dest = rdIdx;
        iClass    = ClassNop;
        case (opcode[10:5])
            GroupR:
            begin
                iClass = ClassR;
                case (opcode[4:0])
                    5'b00000: ctrl.aluOp = AluAdd;
                    5'b00010: ctrl.aluOp = AluAnd;
                    5'b00100: ctrl.aluOp = AluEor;
                    5'b00101: ctrl.aluOp = AluEnor;
                    5'b00110: ctrl.aluOp = AluLsl;
                    5'b00111: ctrl.aluOp = AluLsr;
                    5'b01000: ctrl.aluOp = AluOr;
                    5'b01001: ctrl.aluOp = AluSub;
                    default:  iClass = ClassNop;
                endcase
                // Shift amount comes in through the immediate path
                ctrl.useImm = (ctrl.aluOp == AluLsl) || (ctrl.aluOp == AluLsr);
            end
            GroupI:
            begin
                iClass      = ClassI;
                ctrl.useImm = 1'b1;
                // Bit 21 already belongs to imm12
                case (opcode[4:1])
                    4'b0000: ctrl.aluOp = AluAdd;
                    4'b0010: ctrl.aluOp = AluAnd;
                    4'b0100: ctrl.aluOp = AluEor;
                    4'b0101: ctrl.aluOp = AluEnor;
                    4'b0110: ctrl.aluOp = AluOr;
                    4'b0111: ctrl.aluOp = AluSub;
                    default: iClass = ClassNop;
                endcase
            end
            GroupD:
            begin
                iClass      = ClassD;
                ctrl.useImm = 1'b1;
                ctrl.aluOp  = AluAdd;
                case (opcode[4:0])
                    5'b00000: ctrl.memRead = 1'b1;
                    5'b00001: ctrl.memWrite = 1'b1;
                    default:  iClass = ClassNop;
                endcase
            end
            default:
                iClass = ClassNop;
        endcase

        // Everything but a store writes Rd
        ctrl.regWrite = !ctrl.memWrite;
        if (iClass == ClassNop)
            ctrl = CtrlNop;
    end

    // STUR reads its store data from Rt
    assign rmIdx = ctrl.memWrite ? rdIdx : instrWord[`RM_MSB:`RM_LSB];

    always_comb
    begin
        case (iClass)
            ClassR:  immValue = word_t'(instrWord[`SHAMT_MSB:`SHAMT_LSB]);
            ClassI:  immValue = word_t'(instrWord[`IMM12_MSB:`IMM12_LSB]);
            ClassD:  immValue = word_t'(signed'(instrWord[`DTADDR_MSB:`DTADDR_LSB]));
            default: immValue = '0;
        endcase
    end

endmodule

// ==== alu/alu64.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module alu64 (
    input  cpuPkg::aluOp_t aluOp,
    input  cpuPkg::word_t  a,
    input  cpuPkg::word_t  b,
    output cpuPkg::word_t  result
);
    import cpuPkg::*;

    word_t bInt;
    word_t g;
    word_t p;
    word_t carry;
    logic  invertB;
    logic  arith;
    logic  cin;
    logic [$clog2(`WORD_W)-1:0] shamt;

    // SUB and ENOR both see the complement of b
    assign invertB = (aluOp == AluSub) || (aluOp == AluEnor);
    assign cin     = (aluOp == AluSub);
    // Carries only reach the sum for ADD and SUB
    assign arith   = (aluOp == AluAdd) || (aluOp == AluSub);

    // Per-bit generate and propagate
    assign bInt = b ^ {`WORD_W{invertB}};
    assign g    = a & bInt;
    assign p    = a ^ bInt;

    lacTree #(.WIDTH(`WORD_W)) i_lacTree (
        .g    (g),
        .p    (p),
        .cin  (cin),
        .c    (carry),
        .gOut (),
        .pOut ()
    );

    assign shamt = b[$clog2(`WORD_W)-1:0];

    always_comb
    begin
        case (aluOp)
            AluAnd:  result = a & b;
            AluOr:   result = a | b;
            AluLsl:  result = a << shamt;
            AluLsr:  result = a >> shamt;
            // EOR, ENOR, ADD, SUB
            default: result = p ^ (carry & {`WORD_W{arith}});
        endcase
    end

endmodule

// ==== alu/lacTree.sv ====
`timescale 1ns/10ps

module lacTree #(
    parameter int WIDTH = 64
) (
    input  logic [WIDTH-1:0] g,
    input  logic [WIDTH-1:0] p,
    input  logic             cin,
    output logic [WIDTH-1:0] c,
    output logic             gOut,
    output logic             pOut
);

    generate
        if (WIDTH == 2)
        begin : g_leaf
            // Basic two-bit lookahead cell
            assign c[0] = cin;
            assign c[1] = g[0] | (p[0] & cin);
            assign gOut = g[1] | (p[1] & g[0]);
            assign pOut = p[1] & p[0];
        end
        else
        begin : g_node
            logic [1:0] subCin;
            logic [1:0] subG;
            logic [1:0] subP;

            lacTree #(.WIDTH(WIDTH/2)) i_low (
                .g    (g[WIDTH/2-1:0]),
                .p    (p[WIDTH/2-1:0]),
                .cin  (subCin[0]),
                .c    (c[WIDTH/2-1:0]),
                .gOut (subG[0]),
                .pOut (subP[0])
            );

            lacTree #(.WIDTH(WIDTH/2)) i_high (
                .g    (g[WIDTH-1:WIDTH/2]),
                .p    (p[WIDTH-1:WIDTH/2]),
                .cin  (subCin[1]),
                .c    (c[WIDTH-1:WIDTH/2]),
                .gOut (subG[1]),
                .pOut (subP[1])
            );

            // Root combines the halves and feeds their carry-ins
            lacTree #(.WIDTH(2)) i_root (
                .g    (subG),
                .p    (subP),
                .cin  (cin),
                .c    (subCin),
                .gOut (gOut),
                .pOut (pOut)
            );
        end
    endgenerate

endmodule

// ==== common/cpuPkg.sv ====
`include "cpu_config.svh"

package cpuPkg;

    typedef logic [`WORD_W-1:0]    word_t;
    typedef logic [`INSTR_W-1:0]   instr_t;
    typedef logic [`REG_IDX_W-1:0] regIdx_t;

    // ALU select codes
    typedef enum logic [2:0] {
        AluEor  = 3'b000,
        AluEnor = 3'b001,
        AluAdd  = 3'b010,
        AluSub  = 3'b011,
        AluOr   = 3'b100,
        AluLsl  = 3'b101,
        AluAnd  = 3'b110,
        AluLsr  = 3'b111
    } aluOp_t;

    typedef enum logic [1:0] {
        ClassR,
        ClassI,
        ClassD,
        ClassNop
    } instrClass_t;

    // Control word that follows an instruction down the pipeline
    typedef struct packed {
        aluOp_t  aluOp;
        logic    useImm;
        logic    memRead;
        logic    memWrite;
        logic    regWrite;
        regIdx_t dest;
    } ctrl_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  read;
        logic  write;
    } memReq_t;

    // Bubble: no register write, no memory access
    localparam ctrl_t CtrlNop = '{
        aluOp:    AluEor,
        useImm:   1'b0,
        memRead:  1'b0,
        memWrite: 1'b0,
        regWrite: 1'b0,
        dest:     regIdx_t'(`ZERO_REG)
    };

endpackage

// ==== common/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath widths
`define WORD_W      64
`define INSTR_W     32
`define REG_IDX_W   5

// Register 31 reads as zero and ignores writes
`define ZERO_REG    31
`define PC_STEP     4

// Instruction field positions
`define OPCODE_MSB  31
`define OPCODE_LSB  21
`define RM_MSB      20
`define RM_LSB      16
`define SHAMT_MSB   15
`define SHAMT_LSB   10
`define IMM12_MSB   21
`define IMM12_LSB   10
`define DTADDR_MSB  20
`define DTADDR_LSB  12
`define RN_MSB      9
`define RN_LSB      5
`define RD_MSB      4
`define RD_LSB      0

`endif
